//--- Bender.yml
package:
  name: br_cluster

sources:
  - common/cpu_params_pkg.sv
  - common/br_types_pkg.sv
  - br_rs/rs_entry.sv
  - br_rs/br_rs.sv
  - verilog/prf.sv
  - verilog/fu_br.sv
  - verilog/br_cluster_top.sv
  - target: test
    files:
      - verification/br_cluster_tb.sv

//--- all.f
common/cpu_params_pkg.sv
common/br_types_pkg.sv
br_rs/rs_entry.sv
br_rs/br_rs.sv
verilog/prf.sv
verilog/fu_br.sv
verilog/br_cluster_top.sv
verification/br_cluster_tb.sv

//--- br_rs/br_rs.sv
`timescale 1ns/1ps

module br_rs #(
    parameter int BRRS_DEPTH = 4,
    parameter int CDB_WIDTH  = 2
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    dispatch_valid,
    input  br_types_pkg::br_uop_t                   dispatch_uop,
    output logic                                    dispatch_ready,
    input  br_types_pkg::cdb_t [CDB_WIDTH-1:0]      cdb,
    output logic [cpu_params_pkg::PHY_REG_BITS-1:0] prf_rs1_phy,
    output logic [cpu_params_pkg::PHY_REG_BITS-1:0] prf_rs2_phy,
    input  logic [cpu_params_pkg::XLEN-1:0]         rs1_value,
    input  logic [cpu_params_pkg::XLEN-1:0]         rs2_value,
    output logic                                    issue_valid,
    output br_types_pkg::fu_br_in_t                 issue,
    input  logic                                    fu_ready
);

    import cpu_params_pkg::*;
    import br_types_pkg::*;

    logic [BRRS_DEPTH-1:0]         slot_valid;
    logic [BRRS_DEPTH-1:0]         slot_request;
    logic [BRRS_DEPTH-1:0]         slot_select;
    logic [BRRS_DEPTH-1:0]         slot_grant;
    logic [BRRS_DEPTH-1:0]         slot_push;
    br_rs_entry_t [BRRS_DEPTH-1:0] slot_entry;
    br_rs_entry_t                  dispatch_entry;
    br_rs_entry_t                  issued_entry;

    ////////////////////////////////////////////////////////////////////////////
    // slot array
    ////////////////////////////////////////////////////////////////////////////

    assign dispatch_entry.rob_id         = dispatch_uop.rob_id;
    assign dispatch_entry.rs1_phy        = dispatch_uop.rs1_phy;
    assign dispatch_entry.rs1_valid      = dispatch_uop.rs1_valid;
    assign dispatch_entry.rs2_phy        = dispatch_uop.rs2_phy;
    assign dispatch_entry.rs2_valid      = dispatch_uop.rs2_valid;
    assign dispatch_entry.rd_phy         = dispatch_uop.rd_phy;
    assign dispatch_entry.rd_arch        = dispatch_uop.rd_arch;
    assign dispatch_entry.imm            = dispatch_uop.imm;
    assign dispatch_entry.pc             = dispatch_uop.pc;
    assign dispatch_entry.fu_opcode      = dispatch_uop.fu_opcode;
    assign dispatch_entry.predict_taken  = dispatch_uop.predict_taken;
    assign dispatch_entry.predict_target = dispatch_uop.predict_target;

    for (genvar i = 0; i < BRRS_DEPTH; i++) begin : slots
        logic [PHY_REG_BITS-1:0] src1_phy;
        logic [PHY_REG_BITS-1:0] src2_phy;

        // on the push edge the slot must watch the incoming tags
        assign src1_phy = slot_push[i] ? dispatch_entry.rs1_phy : slot_entry[i].rs1_phy;
        assign src2_phy = slot_push[i] ? dispatch_entry.rs2_phy : slot_entry[i].rs2_phy;

        rs_entry #(
            .CDB_WIDTH     (CDB_WIDTH),
            .RS_ENTRY_T    (br_rs_entry_t)
        ) u_entry (
            .clk           (clk),
            .reset         (reset),
            .push_en       (slot_push[i]),
            .entry_in      (dispatch_entry),
            .src1_ready_in (dispatch_entry.rs1_valid),
            .src2_ready_in (dispatch_entry.rs2_valid),
            .src1_phy      (src1_phy),
            .src2_phy      (src2_phy),
            .grant         (slot_grant[i]),
            .cdb           (cdb),
            .valid         (slot_valid[i]),
            .request       (slot_request[i]),
            .entry         (slot_entry[i])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // allocate and select
    ////////////////////////////////////////////////////////////////////////////

    assign dispatch_ready = ~&slot_valid;

    // first free slot takes the micro-op
    always_comb begin
        slot_push = '0;
        for (int i = BRRS_DEPTH - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                slot_push = '0;
                slot_push[i] = dispatch_valid;
            end
        end
    end

    // lowest index request wins, independent of fu_ready
    always_comb begin
        slot_select = '0;
        for (int i = BRRS_DEPTH - 1; i >= 0; i--) begin
            if (slot_request[i]) begin
                slot_select = '0;
                slot_select[i] = 1'b1;
            end
        end
    end

    assign slot_grant  = slot_select & {BRRS_DEPTH{fu_ready}};
    assign issue_valid = |slot_request;

    // one-hot and-or mux
    always_comb begin
        issued_entry = '0;
        for (int i = 0; i < BRRS_DEPTH; i++) begin
            issued_entry = br_rs_entry_t'(issued_entry |
                (slot_entry[i] & {$bits(br_rs_entry_t){slot_select[i]}}));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // operand read and issue
    ////////////////////////////////////////////////////////////////////////////

    assign prf_rs1_phy = issued_entry.rs1_phy;
    assign prf_rs2_phy = issued_entry.rs2_phy;

    assign issue.rob_id         = issued_entry.rob_id;
    assign issue.rd_phy         = issued_entry.rd_phy;
    assign issue.rd_arch        = issued_entry.rd_arch;
    assign issue.fu_opcode      = issued_entry.fu_opcode;
    assign issue.imm            = issued_entry.imm;
    assign issue.pc             = issued_entry.pc;
    assign issue.predict_taken  = issued_entry.predict_taken;
    assign issue.predict_target = issued_entry.predict_target;
    assign issue.rs1_value      = rs1_value;
    assign issue.rs2_value      = rs2_value;

endmodule

//--- br_rs/rs_entry.sv
`timescale 1ns/1ps

module rs_entry #(
    parameter int  CDB_WIDTH  = 2,
    parameter type RS_ENTRY_T = logic
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    push_en,
    input  RS_ENTRY_T                               entry_in,
    input  logic                                    src1_ready_in,
    input  logic                                    src2_ready_in,
    input  logic [cpu_params_pkg::PHY_REG_BITS-1:0] src1_phy,
    input  logic [cpu_params_pkg::PHY_REG_BITS-1:0] src2_phy,
    input  logic                                    grant,
    input  br_types_pkg::cdb_t [CDB_WIDTH-1:0]      cdb,
    output logic                                    valid,
    output logic                                    request,
    output RS_ENTRY_T                               entry
);

    logic src1_ready;
    logic src2_ready;
    logic src1_hit;
    logic src2_hit;

    // tag 0 is hardwired zero, so it never waits
    // src tags come from entry_in on the push edge, else from the stored payload
    always_comb begin
        src1_hit = (src1_phy == '0);
        src2_hit = (src2_phy == '0);
        for (int i = 0; i < CDB_WIDTH; i++) begin
            if (cdb[i].valid && cdb[i].rd_phy == src1_phy) begin
                src1_hit = 1'b1;
            end
            if (cdb[i].valid && cdb[i].rd_phy == src2_phy) begin
                src2_hit = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid      <= 1'b0;
            src1_ready <= 1'b0;
            src2_ready <= 1'b0;
        end else if (push_en) begin
            valid      <= 1'b1;
            src1_ready <= src1_ready_in | src1_hit;
            src2_ready <= src2_ready_in | src2_hit;
        end else if (grant) begin
            valid      <= 1'b0;
        end else begin
            src1_ready <= src1_ready | src1_hit;
            src2_ready <= src2_ready | src2_hit;
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (push_en) begin
            entry <= entry_in;
        end
    end

    assign request = valid & src1_ready & src2_ready;

endmodule

//--- common/br_types_pkg.sv
package br_types_pkg;

    import cpu_params_pkg::*;

    typedef enum logic [2:0] {
        beq  = 3'd0,
        bne  = 3'd1,
        blt  = 3'd2,
        bge  = 3'd3,
        bltu = 3'd4,
        bgeu = 3'd5,
        jal  = 3'd6,
        jalr = 3'd7
    } br_op_t;

    // micro-op as delivered by dispatch
    typedef struct packed {
        logic [ROB_ID_BITS-1:0]   rob_id;
        logic [PHY_REG_BITS-1:0]  rs1_phy;
        logic                     rs1_valid;
        logic [PHY_REG_BITS-1:0]  rs2_phy;
        logic                     rs2_valid;
        logic [PHY_REG_BITS-1:0]  rd_phy;
        logic [ARCH_REG_BITS-1:0] rd_arch;
        logic [XLEN-1:0]          imm;
        logic [XLEN-1:0]          pc;
        br_op_t                   fu_opcode;
        logic                     predict_taken;
        logic [XLEN-1:0]          predict_target;
    } br_uop_t;

    // payload of one station slot
    // the valid bits only seed the slot's ready state
    typedef struct packed {
        logic [ROB_ID_BITS-1:0]   rob_id;
        logic [PHY_REG_BITS-1:0]  rs1_phy;
        logic                     rs1_valid;
        logic [PHY_REG_BITS-1:0]  rs2_phy;
        logic                     rs2_valid;
        logic [PHY_REG_BITS-1:0]  rd_phy;
        logic [ARCH_REG_BITS-1:0] rd_arch;
        logic [XLEN-1:0]          imm;
        logic [XLEN-1:0]          pc;
        br_op_t                   fu_opcode;
        logic                     predict_taken;
        logic [XLEN-1:0]          predict_target;
    } br_rs_entry_t;

    // one common data bus write
    typedef struct packed {
        logic                    valid;
        logic [PHY_REG_BITS-1:0] rd_phy;
        logic [XLEN-1:0]         rd_value;
    } cdb_t;

    // issued branch with operands attached
    typedef struct packed {
        logic [ROB_ID_BITS-1:0]   rob_id;
        logic [PHY_REG_BITS-1:0]  rd_phy;
        logic [ARCH_REG_BITS-1:0] rd_arch;
        br_op_t                   fu_opcode;
        logic [XLEN-1:0]          imm;
        logic [XLEN-1:0]          pc;
        logic                     predict_taken;
        logic [XLEN-1:0]          predict_target;
        logic [XLEN-1:0]          rs1_value;
        logic [XLEN-1:0]          rs2_value;
    } fu_br_in_t;

    typedef struct packed {
        logic [ROB_ID_BITS-1:0]   rob_id;
        logic [PHY_REG_BITS-1:0]  rd_phy;
        logic [ARCH_REG_BITS-1:0] rd_arch;
        logic                     taken;
        logic [XLEN-1:0]          target;
        logic                     mispredict;
        logic [XLEN-1:0]          link_value;
    } br_result_t;

endpackage

//--- common/cpu_params_pkg.sv
package cpu_params_pkg;

    // data path and address width
    localparam int XLEN = 32;

    // physical register tag, 64 registers
    localparam int PHY_REG_BITS = 6;

    // reorder buffer tag
    localparam int ROB_ID_BITS = 5;

    // architectural register index
    localparam int ARCH_REG_BITS = 5;

endpackage

//--- verification/br_cluster_tb.sv
`timescale 1ns/1ps

module br_cluster_tb;

    import cpu_params_pkg::*;
    import br_types_pkg::*;

    localparam int BRRS_DEPTH = 4;
    localparam int CDB_WIDTH  = 2;
    localparam int NUM_REGS   = 2 ** PHY_REG_BITS;
    localparam int CLK_PERIOD = 100;
    localparam int MAX_WAIT   = 300;

    logic                    clk;
    logic                    reset;
    logic                    dispatch_valid;
    br_uop_t                 dispatch_uop;
    logic                    dispatch_ready;
    cdb_t [CDB_WIDTH-1:0]    cdb;
    logic                    result_valid;
    br_result_t              result;
    logic                    result_ready;

    integer                  seed = 32'hec73_c81f;

    // reference model state
    logic [XLEN-1:0]         shadow [NUM_REGS];
    bit                      written [NUM_REGS];
    int                      mark [NUM_REGS];
    br_result_t              expected [logic [ROB_ID_BITS-1:0]];
    time                     wake_time [2 ** ROB_ID_BITS];
    br_uop_t                 uops [$];
    logic [PHY_REG_BITS-1:0] wr_tag [$];
    int                      wr_owner [$];
    logic [ROB_ID_BITS-1:0]  next_rob;
    bit                      bp_on;
    bit                      held;
    br_result_t              held_result;
    int                      value_errors;
    int                      other_errors;
    int                      timeouts;

    br_cluster_top #(
        .BRRS_DEPTH     (BRRS_DEPTH),
        .CDB_WIDTH      (CDB_WIDTH)
    ) dut (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_uop   (dispatch_uop),
        .dispatch_ready (dispatch_ready),
        .cdb            (cdb),
        .result_valid   (result_valid),
        .result         (result),
        .result_ready   (result_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic br_result_t resolve_branch(input br_uop_t u, input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        br_result_t      r;
        logic [XLEN-1:0] dest;
        r = '0;
        r.rob_id  = u.rob_id;
        r.rd_phy  = u.rd_phy;
        r.rd_arch = u.rd_arch;
        case (u.fu_opcode)
            beq:     r.taken = (a == b);
            bne:     r.taken = (a != b);
            blt:     r.taken = ($signed(a) < $signed(b));
            bge:     r.taken = ($signed(a) >= $signed(b));
            bltu:    r.taken = (a < b);
            bgeu:    r.taken = (a >= b);
            default: r.taken = 1'b1;
        endcase
        if (u.fu_opcode == jalr) begin
            dest = (a + u.imm) & 32'hffff_fffe;
        end else begin
            dest = u.pc + u.imm;
        end
        r.link_value = u.pc + 32'd4;
        r.target     = r.taken ? dest : r.link_value;
        r.mispredict = (r.taken != u.predict_taken) || (r.taken && r.target != u.predict_target);
        return r;
    endfunction

    // kind 0 tag zero, 1 fresh tag written later, 2 tag written earlier, 3 any
    function automatic logic [PHY_REG_BITS-1:0] pick_source(input int owner, input int kind,
                                                            output logic ready);
        logic [PHY_REG_BITS-1:0] tag;
        logic [PHY_REG_BITS-1:0] start;
        logic [PHY_REG_BITS-1:0] cand;
        int                      choice;
        tag    = '0;
        ready  = 1'b1;
        choice = (kind == 3) ? int'($unsigned($random(seed)) % 3) : kind;
        start  = PHY_REG_BITS'($random(seed));
        if (choice == 2 && start != '0 && written[start] && mark[start] != 2) begin
            tag       = start;
            mark[tag] = 1;
        end else if (choice == 1) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                cand = PHY_REG_BITS'(int'(start) + i);
                if (tag == '0 && cand != '0 && mark[cand] == 0) begin
                    tag = cand;
                end
            end
            mark[tag]    = 2;
            written[tag] = 1'b1;
            // small values now and then so equal compares happen
            shadow[tag]  = (($random(seed) & 1) != 0) ? XLEN'($random(seed))
                                                      : XLEN'($random(seed) % 3);
            ready        = 1'b0;
            wr_tag.push_back(tag);
            wr_owner.push_back(owner);
        end else begin
            // tag 0 is ready even when not flagged valid
            ready = 1'($random(seed));
        end
        return tag;
    endfunction

    function automatic br_uop_t make_uop(input int owner, input int kind);
        br_uop_t     u;
        br_result_t  r;
        logic        ready1;
        logic        ready2;
        logic [11:0] imm12;
        u           = '0;
        u.rob_id    = next_rob;
        next_rob    = next_rob + 1'b1;
        u.rs1_phy   = pick_source(owner, kind, ready1);
        u.rs1_valid = ready1;
        u.rs2_phy   = pick_source(owner, kind, ready2);
        u.rs2_valid = ready2;
        u.rd_phy    = PHY_REG_BITS'($random(seed));
        u.rd_arch   = ARCH_REG_BITS'($random(seed));
        imm12       = 12'($random(seed));
        u.imm       = {{(XLEN-12){imm12[11]}}, imm12};
        u.pc        = XLEN'($random(seed)) & ~XLEN'(3);
        u.fu_opcode = br_op_t'(3'($random(seed)));
        r = resolve_branch(u, shadow[u.rs1_phy], shadow[u.rs2_phy]);
        u.predict_taken  = 1'($random(seed));
        u.predict_target = (($random(seed) & 1) != 0) ? r.target : XLEN'($random(seed));
        return u;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic wait_results();
        int cycles;
        cycles = 0;
        while (expected.num() != 0 && cycles < MAX_WAIT) begin
            @(posedge clk);
            cycles++;
        end
        if (expected.num() != 0) begin
            timeouts++;
            $display("timeout: %0d branch results never came back", expected.num());
        end
    endtask

    // hold keeps all sources unwritten until the station is full plus one
    task automatic run_batch(input int n, input bit hold);
        br_uop_t u;
        cdb_t    w;
        int      sent;
        int      wr_next;
        int      cycles;
        int      total;
        bit      block_checked;
        uops.delete();
        wr_tag.delete();
        wr_owner.delete();
        for (int t = 0; t < NUM_REGS; t++) begin
            mark[t] = 0;
        end
        for (int k = 0; k < n; k++) begin
            uops.push_back(make_uop(k, hold ? 1 : 3));
        end
        if (hold) begin
            uops.push_back(make_uop(n, 0));
        end
        foreach (uops[k]) begin
            u = uops[k];
            expected[u.rob_id]  = resolve_branch(u, shadow[u.rs1_phy], shadow[u.rs2_phy]);
            wake_time[u.rob_id] = 0;
        end
        total         = uops.size();
        sent          = 0;
        wr_next       = 0;
        cycles        = 0;
        block_checked = 1'b0;
        while ((sent < total || wr_next < wr_tag.size()) && cycles < MAX_WAIT) begin
            dispatch_valid <= (sent < total);
            if (sent < total) begin
                dispatch_uop <= uops[sent];
            end
            // writes go out on or after the owner's dispatch edge
            for (int p = 0; p < CDB_WIDTH; p++) begin
                w = '0;
                if (wr_next < wr_tag.size() && wr_owner[wr_next] <= sent &&
                    (!hold || sent >= n) && ($random(seed) & 1) != 0) begin
                    w.valid    = 1'b1;
                    w.rd_phy   = wr_tag[wr_next];
                    w.rd_value = shadow[wr_tag[wr_next]];
                    wake_time[uops[wr_owner[wr_next]].rob_id] = $time + CLK_PERIOD;
                    wr_next++;
                end
                // stray writes to tag 0 must be dropped
                if (!w.valid && ($random(seed) & 3) == 0) begin
                    w.valid    = 1'b1;
                    w.rd_value = XLEN'($random(seed));
                end
                cdb[p] <= w;
            end
            @(posedge clk);
            cycles++;
            if (hold && sent == n && !block_checked) begin
                block_checked = 1'b1;
                assert (!dispatch_ready) else begin
                    value_errors++;
                    $display("ERR %0t: dispatch_ready high with %0d slots taken", $time, n);
                end
            end
            if (sent < total && dispatch_ready) begin
                sent++;
            end
        end
        dispatch_valid <= 1'b0;
        cdb            <= '0;
        if (sent < total || wr_next < wr_tag.size()) begin
            timeouts++;
            $display("timeout: only %0d of %0d branches were accepted", sent, total);
        end else begin
            wait_results();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // result monitor
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_result(input br_result_t got);
        assert (expected.exists(got.rob_id)) else begin
            other_errors++;
            $display("result for rob_id %0d arrived twice or was never sent", got.rob_id);
        end
        if (expected.exists(got.rob_id)) begin
            assert (got == expected[got.rob_id]) else begin
                value_errors++;
                $display("ERR %0t: rob_id %0d got %h expected %h", $time, got.rob_id, got,
                         expected[got.rob_id]);
            end
            assert ($time >= wake_time[got.rob_id] + 2 * CLK_PERIOD) else begin
                value_errors++;
                $display("ERR %0t: rob_id %0d resolved before its sources were written", $time,
                         got.rob_id);
            end
            expected.delete(got.rob_id);
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (held) begin
                assert (result_valid && result == held_result) else begin
                    value_errors++;
                    $display("ERR %0t: held result changed or dropped", $time);
                end
            end
            if (result_valid && result_ready) begin
                check_result(result);
            end
            held        = result_valid && !result_ready;
            held_result = result;
        end
    end

    always @(posedge clk) begin
        if (bp_on) begin
            result_ready <= (($random(seed) & 3) != 0);
        end else begin
            result_ready <= 1'b1;
        end
    end

    initial begin
        clk            = 1'b0;
        reset          <= 1'b1;
        dispatch_valid <= 1'b0;
        dispatch_uop   <= '0;
        cdb            <= '0;
        result_ready   <= 1'b1;
        next_rob       = '0;
        bp_on          = 1'b0;
        held           = 1'b0;
        value_errors   = 0;
        other_errors   = 0;
        timeouts       = 0;
        for (int t = 0; t < NUM_REGS; t++) begin
            shadow[t]  = '0;
            written[t] = 1'b0;
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        assert (dispatch_ready && !result_valid) else begin
            value_errors++;
            $display("ERR %0t: wrong dispatch_ready or result_valid after reset", $time);
        end

        for (int b = 0; b < 40 && timeouts == 0; b++) begin
            run_batch(1 + int'($unsigned($random(seed)) % BRRS_DEPTH), 1'b0);
        end
        if (timeouts == 0) begin
            run_batch(BRRS_DEPTH, 1'b1);
        end
        // random back-pressure from here on
        bp_on = 1'b1;
        for (int b = 0; b < 40 && timeouts == 0; b++) begin
            run_batch(1 + int'($unsigned($random(seed)) % BRRS_DEPTH), 1'b0);
        end
        if (timeouts == 0) begin
            run_batch(BRRS_DEPTH, 1'b1);
        end
        repeat (5) @(posedge clk);

        $display("errors: %0d value, %0d protocol, %0d timeouts", value_errors, other_errors,
                 timeouts);
        if (value_errors == 0 && other_errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- verilog/br_cluster_top.sv
`timescale 1ns/1ps

module br_cluster_top #(
    parameter int BRRS_DEPTH = 4,
    parameter int CDB_WIDTH  = 2
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               dispatch_valid,
    input  br_types_pkg::br_uop_t              dispatch_uop,
    output logic                               dispatch_ready,
    input  br_types_pkg::cdb_t [CDB_WIDTH-1:0] cdb,
    output logic                               result_valid,
    output br_types_pkg::br_result_t           result,
    input  logic                               result_ready
);

    import cpu_params_pkg::*;
    import br_types_pkg::*;

    logic [PHY_REG_BITS-1:0] prf_rs1_phy;
    logic [PHY_REG_BITS-1:0] prf_rs2_phy;
    logic [XLEN-1:0]         rs1_value;
    logic [XLEN-1:0]         rs2_value;
    logic                    issue_valid;
    fu_br_in_t               issue;
    logic                    fu_ready;

    br_rs #(
        .BRRS_DEPTH     (BRRS_DEPTH),
        .CDB_WIDTH      (CDB_WIDTH)
    ) u_br_rs (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_uop   (dispatch_uop),
        .dispatch_ready (dispatch_ready),
        .cdb            (cdb),
        .prf_rs1_phy    (prf_rs1_phy),
        .prf_rs2_phy    (prf_rs2_phy),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .fu_ready       (fu_ready)
    );

    prf #(
        .CDB_WIDTH (CDB_WIDTH)
    ) u_prf (
        .clk       (clk),
        .reset     (reset),
        .cdb       (cdb),
        .rs1_phy   (prf_rs1_phy),
        .rs2_phy   (prf_rs2_phy),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    fu_br u_fu_br (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .fu_ready     (fu_ready),
        .result_valid (result_valid),
        .result       (result),
        .result_ready (result_ready)
    );

endmodule

//--- verilog/fu_br.sv
`timescale 1ns/1ps

module fu_br (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     issue_valid,
    input  br_types_pkg::fu_br_in_t  issue,
    output logic                     fu_ready,
    output logic                     result_valid,
    output br_types_pkg::br_result_t result,
    input  logic                     result_ready
);

    import cpu_params_pkg::*;
    import br_types_pkg::*;

    logic            is_eq;
    logic            is_lt;
    logic            is_ltu;
    logic            taken;
    logic [XLEN-1:0] jump_target;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] target;
    logic            mispredict;

    ////////////////////////////////////////////////////////////////////////////
    // resolve
    ////////////////////////////////////////////////////////////////////////////

    assign is_eq  = (issue.rs1_value == issue.rs2_value);
    assign is_lt  = ($signed(issue.rs1_value) < $signed(issue.rs2_value));
    assign is_ltu = (issue.rs1_value < issue.rs2_value);

    always_comb begin
        case (issue.fu_opcode)
            beq:       taken = is_eq;
            bne:       taken = ~is_eq;
            blt:       taken = is_lt;
            bge:       taken = ~is_lt;
            bltu:      taken = is_ltu;
            bgeu:      taken = ~is_ltu;
            jal, jalr: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    // jalr clears bit 0 of the sum
    assign jump_target = (issue.fu_opcode == jalr)
                       ? ((issue.rs1_value + issue.imm) & ~XLEN'(1))
                       : (issue.pc + issue.imm);
    assign next_pc     = issue.pc + XLEN'(4);
    assign target      = taken ? jump_target : next_pc;
    assign mispredict  = (taken != issue.predict_taken) ||
                         (taken && (target != issue.predict_target));

    ////////////////////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////////////////////

    // accept when empty or draining this cycle
    assign fu_ready = ~result_valid | result_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else if (issue_valid && fu_ready) begin
            result_valid <= 1'b1;
        end else if (result_ready) begin
            result_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && fu_ready) begin
            result.rob_id     <= issue.rob_id;
            result.rd_phy     <= issue.rd_phy;
            result.rd_arch    <= issue.rd_arch;
            result.taken      <= taken;
            result.target     <= target;
            result.mispredict <= mispredict;
            result.link_value <= next_pc;
        end
    end

endmodule

//--- verilog/prf.sv
`timescale 1ns/1ps

module prf #(
    parameter int CDB_WIDTH = 2
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  br_types_pkg::cdb_t [CDB_WIDTH-1:0]      cdb,
    input  logic [cpu_params_pkg::PHY_REG_BITS-1:0] rs1_phy,
    input  logic [cpu_params_pkg::PHY_REG_BITS-1:0] rs2_phy,
    output logic [cpu_params_pkg::XLEN-1:0]         rs1_value,
    output logic [cpu_params_pkg::XLEN-1:0]         rs2_value
);

    import cpu_params_pkg::*;

    localparam int NUM_REGS = 2 ** PHY_REG_BITS;

    logic [XLEN-1:0] regs [NUM_REGS];

    // register 0 is never written and stays zero after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int i = 0; i < CDB_WIDTH; i++) begin
                if (cdb[i].valid && cdb[i].rd_phy != '0) begin
                    regs[cdb[i].rd_phy] <= cdb[i].rd_value;
                end
            end
        end
    end

    // combinational read, same-cycle cdb write forwarded
    function automatic logic [XLEN-1:0] read_reg(input logic [PHY_REG_BITS-1:0] phy);
        logic [XLEN-1:0] value;
        value = regs[phy];
        for (int i = 0; i < CDB_WIDTH; i++) begin
            if (cdb[i].valid && cdb[i].rd_phy == phy) begin
                value = cdb[i].rd_value;
            end
        end
        if (phy == '0) begin
            value = '0;
        end
        return value;
    endfunction

    always_comb begin
        rs1_value = read_reg(rs1_phy);
        rs2_value = read_reg(rs2_phy);
    end

endmodule
